//--- common/xcorr_pkg.sv
package xcorr_pkg;

	// One word on the packet stream
	typedef logic [15:0] word_t;

	typedef enum logic [1:0] {
		WK_HEADER,
		WK_AUTO,
		WK_CROSS
	} word_kind_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_HEADER,
		TX_PAYLOAD
	} tx_state_e;

	localparam logic [3:0] FRAME_TAG = 4'hA;

	// Header word fields
	localparam int SEQ_W        = 8;
	localparam int DROP_W       = 4;
	localparam int HDR_SEQ_LSB  = 0;
	localparam int HDR_DROP_LSB = 8;
	localparam int HDR_TAG_LSB  = 12;

	// Line pairs i<j
	function automatic int num_baselines(int num_lines);
		return num_lines * (num_lines - 1) / 2;
	endfunction

	// Header plus one word per auto and cross term
	function automatic int frame_words(int num_lines, int max_lag);
		return 1 + (num_lines + num_baselines(num_lines)) * max_lag;
	endfunction

	function automatic word_t header_word(logic [SEQ_W-1:0] seq, logic [DROP_W-1:0] dropped);
		word_t w;
		w = '0;
		w[HDR_TAG_LSB +: 4]       = FRAME_TAG;
		w[HDR_DROP_LSB +: DROP_W] = dropped;
		w[HDR_SEQ_LSB +: SEQ_W]   = seq;
		return w;
	endfunction

endpackage

//--- common/frame_buf_if.sv
`timescale 1ns/1ps

interface frame_buf_if import xcorr_pkg::*; #(
	parameter int IDX_W = 8
);

	logic             window_end; // Last sample of the window is on the taps
	logic             keep;       // Transmitter is free, snapshot this window
	logic [IDX_W-1:0] rd_index;   // Frame position, 0 is the header
	word_t            rd_word;    // Buffer word at rd_index

	// Window timer side
	modport ctrl (
		output window_end,
		output keep
	);

	// Counter bank and snapshot buffer
	modport bank (
		input  window_end,
		input  keep,
		input  rd_index,
		output rd_word
	);

	// Frame serializer
	modport tx (
		input  window_end,
		input  keep,
		input  rd_word,
		output rd_index
	);

endinterface

//--- correlator/tap_delay_line.sv
`timescale 1ns/1ps

module tap_delay_line #(
	parameter int NUM_LINES = 3,
	parameter int MAX_LAG   = 4
) (
	input  logic                              pll_clk,
	input  logic                              arst_n,
	input  logic [NUM_LINES-1:0]              line_in,
	output logic [NUM_LINES-1:0][MAX_LAG-1:0] taps
);

	// Tap k of a line holds the sample taken k cycles before tap 0
	logic [NUM_LINES-1:0][MAX_LAG-1:0] hist;

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			hist <= '0; // No pulses before the first sample
		end else begin
			for (int i = 0; i < NUM_LINES; i++) begin
				hist[i][0] <= line_in[i];
				for (int k = 1; k < MAX_LAG; k++) begin
					hist[i][k] <= hist[i][k-1];
				end
			end
		end
	end

	assign taps = hist;

endmodule

//--- correlator/lag_counter_bank.sv
`timescale 1ns/1ps

module lag_counter_bank import xcorr_pkg::*; #(
	parameter int NUM_LINES  = 3,
	parameter int MAX_LAG    = 4,
	parameter int RESOLUTION = 16
) (
	input  logic                              pll_clk,
	input  logic                              arst_n,
	input  logic [NUM_LINES-1:0][MAX_LAG-1:0] taps,
	frame_buf_if.bank                         buf_port
);

	localparam int NUM_AUTO  = NUM_LINES * MAX_LAG;
	localparam int NUM_TERMS = frame_words(NUM_LINES, MAX_LAG) - 1;
	localparam int IDX_W     = $bits(buf_port.rd_index);

	localparam logic [RESOLUTION-1:0] CNT_MAX = '1;

	logic [NUM_TERMS-1:0]  hit;               // Both taps of a term high this cycle
	logic [RESOLUTION-1:0] cnt     [NUM_TERMS];
	logic [RESOLUTION-1:0] cnt_nxt [NUM_TERMS];
	logic [RESOLUTION-1:0] snap    [NUM_TERMS]; // Frame buffer, header excluded

	// Auto terms, line i against its own history
	for (genvar i = 0; i < NUM_LINES; i++) begin : g_auto
		for (genvar k = 0; k < MAX_LAG; k++) begin : g_lag
			assign hit[i*MAX_LAG + k] = taps[i][0] & taps[i][k];
		end
	end

	// Cross terms, line i now against line j k samples ago
	for (genvar i = 0; i < NUM_LINES - 1; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_LINES; j++) begin : g_col
			localparam int PAIR = i * (2*NUM_LINES - i - 1) / 2 + (j - i - 1);
			for (genvar k = 0; k < MAX_LAG; k++) begin : g_lag
				assign hit[NUM_AUTO + PAIR*MAX_LAG + k] = taps[i][0] & taps[j][k];
			end
		end
	end

	always_comb begin
		for (int t = 0; t < NUM_TERMS; t++) begin
			if (hit[t] && cnt[t] != CNT_MAX) begin
				cnt_nxt[t] = cnt[t] + 1'b1;
			end else begin
				cnt_nxt[t] = cnt[t]; // Holds at full scale
			end
		end
	end

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int t = 0; t < NUM_TERMS; t++) begin
				cnt[t] <= '0;
			end
		end else begin
			for (int t = 0; t < NUM_TERMS; t++) begin
				cnt[t] <= buf_port.window_end ? '0 : cnt_nxt[t];
			end
		end
	end

	// Final counts include the last sample of the window
	always_ff @(posedge pll_clk) begin
		if (buf_port.window_end && buf_port.keep) begin
			for (int t = 0; t < NUM_TERMS; t++) begin
				snap[t] <= cnt_nxt[t];
			end
		end
	end

	always_comb begin
		if (buf_port.rd_index == '0 || buf_port.rd_index > IDX_W'(NUM_TERMS)) begin
			buf_port.rd_word = '0; // Header slot is filled by the transmitter
		end else begin
			buf_port.rd_word = word_t'(snap[buf_port.rd_index - 1'b1]);
		end
	end

endmodule

//--- hdl/integration_ctrl.sv
`timescale 1ns/1ps

module integration_ctrl import xcorr_pkg::*; #(
	parameter int INTEG_CYCLES = 64
) (
	input  logic              pll_clk,
	input  logic              arst_n,
	input  logic              tx_busy,
	output logic [SEQ_W-1:0]  seq,
	output logic [DROP_W-1:0] dropped,
	frame_buf_if.ctrl         buf_port
);

	localparam int CNT_W = (INTEG_CYCLES > 1) ? $clog2(INTEG_CYCLES) : 1;

	localparam logic [CNT_W-1:0]  CNT_LAST = CNT_W'(INTEG_CYCLES - 1);
	localparam logic [DROP_W-1:0] DROP_MAX = '1;

	logic [CNT_W-1:0] cyc_cnt;
	logic             win_end_q;

	// Pulse lands in the cycle that presents the window's last sample
	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc_cnt   <= '0;
			win_end_q <= 1'b0;
		end else if (cyc_cnt == CNT_LAST) begin
			cyc_cnt   <= '0;
			win_end_q <= 1'b1;
		end else begin
			cyc_cnt   <= cyc_cnt + 1'b1;
			win_end_q <= 1'b0;
		end
	end

	assign buf_port.window_end = win_end_q;
	assign buf_port.keep       = win_end_q && !tx_busy; // Frame in flight drops the window

	// Window index, wraps at 256
	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			seq <= '0;
		end else if (win_end_q) begin
			seq <= seq + 1'b1;
		end
	end

	// Drop count since the last kept window
	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			dropped <= '0;
		end else if (win_end_q) begin
			if (!tx_busy) begin
				dropped <= '0; // Transmitter latches the old value now
			end else if (dropped != DROP_MAX) begin
				dropped <= dropped + 1'b1;
			end
		end
	end

endmodule

//--- hdl/frame_tx.sv
`timescale 1ns/1ps

module frame_tx import xcorr_pkg::*; #(
	parameter int NUM_LINES    = 3,
	parameter int MAX_LAG      = 4,
	parameter int CREDIT_DEPTH = 4
) (
	input  logic              pll_clk,
	input  logic              arst_n,
	input  logic [SEQ_W-1:0]  seq,
	input  logic [DROP_W-1:0] dropped,
	input  logic              credit_return,
	frame_buf_if.tx           buf_port,
	output logic              tx_busy,
	output word_t             pkt_word,
	output word_kind_e        pkt_kind,
	output logic              pkt_valid,
	output logic              pkt_last
);

	localparam int FRAME_WORDS = frame_words(NUM_LINES, MAX_LAG);
	localparam int IDX_W       = $bits(buf_port.rd_index);
	localparam int NUM_AUTO    = NUM_LINES * MAX_LAG;
	localparam int CRED_W      = $clog2(CREDIT_DEPTH + 1);

	localparam logic [IDX_W-1:0]  LAST_IDX  = IDX_W'(FRAME_WORDS - 1);
	localparam logic [IDX_W-1:0]  AUTO_LAST = IDX_W'(NUM_AUTO);
	localparam logic [CRED_W-1:0] CRED_FULL = CRED_W'(CREDIT_DEPTH);

	tx_state_e         state;
	logic [IDX_W-1:0]  rd_index;
	logic [CRED_W-1:0] credit;
	logic [SEQ_W-1:0]  hdr_seq;
	logic [DROP_W-1:0] hdr_drop;

	assign tx_busy          = (state != TX_IDLE);
	assign pkt_valid        = tx_busy && (credit != '0); // One word per credit
	assign pkt_last         = pkt_valid && (state == TX_PAYLOAD) && (rd_index == LAST_IDX);
	assign buf_port.rd_index = rd_index;

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= TX_IDLE;
			rd_index <= '0;
			hdr_seq  <= '0;
			hdr_drop <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (buf_port.window_end && buf_port.keep) begin
						hdr_seq  <= seq;
						hdr_drop <= dropped;
						state    <= TX_HEADER;
					end
				end
				TX_HEADER: begin
					if (pkt_valid) begin
						rd_index <= rd_index + 1'b1;
						state    <= TX_PAYLOAD;
					end
				end
				TX_PAYLOAD: begin
					if (pkt_last) begin
						rd_index <= '0;
						state    <= TX_IDLE;
					end else if (pkt_valid) begin
						rd_index <= rd_index + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Credits return from the receiver, one per pulse
	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			credit <= CRED_FULL;
		end else if (pkt_valid && !credit_return) begin
			credit <= credit - 1'b1;
		end else if (!pkt_valid && credit_return && credit != CRED_FULL) begin
			credit <= credit + 1'b1;
		end
	end

	always_comb begin
		if (state != TX_PAYLOAD) begin
			pkt_word = header_word(hdr_seq, hdr_drop);
			pkt_kind = WK_HEADER;
		end else begin
			pkt_word = buf_port.rd_word;
			pkt_kind = (rd_index <= AUTO_LAST) ? WK_AUTO : WK_CROSS; // Auto words come first
		end
	end

endmodule

//--- hdl/xcorr_top.sv
`timescale 1ns/1ps

module xcorr_top import xcorr_pkg::*; #(
	parameter int NUM_LINES    = 3,
	parameter int MAX_LAG      = 4,
	parameter int RESOLUTION   = 16,
	parameter int INTEG_CYCLES = 64,
	parameter int CREDIT_DEPTH = 4
) (
	input  logic                 pll_clk,
	input  logic                 arst_n,
	input  logic [NUM_LINES-1:0] line_in,
	input  logic                 credit_return,
	output word_t                pkt_word,
	output word_kind_e           pkt_kind,
	output logic                 pkt_valid,
	output logic                 pkt_last
);

	// Frame position width, header included
	localparam int IDX_W = $clog2(frame_words(NUM_LINES, MAX_LAG));

	logic [NUM_LINES-1:0][MAX_LAG-1:0] taps;
	logic [SEQ_W-1:0]                  seq;
	logic [DROP_W-1:0]                 dropped;
	logic                              tx_busy;

	frame_buf_if #(.IDX_W(IDX_W)) fb ();

	tap_delay_line #(.NUM_LINES(NUM_LINES), .MAX_LAG(MAX_LAG)) u_taps (
		.pll_clk (pll_clk),
		.arst_n  (arst_n),
		.line_in (line_in),
		.taps    (taps)
	);

	lag_counter_bank #(
		.NUM_LINES  (NUM_LINES),
		.MAX_LAG    (MAX_LAG),
		.RESOLUTION (RESOLUTION)
	) u_bank (
		.pll_clk  (pll_clk),
		.arst_n   (arst_n),
		.taps     (taps),
		.buf_port (fb.bank)
	);

	integration_ctrl #(.INTEG_CYCLES(INTEG_CYCLES)) u_ctrl (
		.pll_clk  (pll_clk),
		.arst_n   (arst_n),
		.tx_busy  (tx_busy),
		.seq      (seq),
		.dropped  (dropped),
		.buf_port (fb.ctrl)
	);

	frame_tx #(
		.NUM_LINES    (NUM_LINES),
		.MAX_LAG      (MAX_LAG),
		.CREDIT_DEPTH (CREDIT_DEPTH)
	) u_tx (
		.pll_clk       (pll_clk),
		.arst_n        (arst_n),
		.seq           (seq),
		.dropped       (dropped),
		.credit_return (credit_return),
		.buf_port      (fb.tx),
		.tx_busy       (tx_busy),
		.pkt_word      (pkt_word),
		.pkt_kind      (pkt_kind),
		.pkt_valid     (pkt_valid),
		.pkt_last      (pkt_last)
	);

endmodule

//--- verif/xcorr_properties.sv
`timescale 1ns/1ps

module xcorr_properties import xcorr_pkg::*; #(
	parameter int NUM_LINES    = 3,
	parameter int MAX_LAG      = 4,
	parameter int CREDIT_DEPTH = 4
) (
	input logic                                pll_clk,
	input logic                                arst_n,
	input logic                                pkt_valid,
	input logic                                pkt_last,
	input logic                                credit_return,
	input logic [$clog2(CREDIT_DEPTH + 1)-1:0] credit
);

	localparam int FRAME_WORDS = frame_words(NUM_LINES, MAX_LAG);

	int err_count = 0;
	int in_flight; // Words sent and not yet paid back
	int word_pos;  // Frame position of the next word

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			in_flight <= 0;
			word_pos  <= 0;
		end else begin
			if (pkt_valid && !credit_return) begin
				in_flight <= in_flight + 1;
			end else if (!pkt_valid && credit_return && in_flight > 0) begin
				in_flight <= in_flight - 1;
			end
			if (pkt_valid) begin
				word_pos <= pkt_last ? 0 : word_pos + 1;
			end
		end
	end

	// A word goes out only against a held credit
	a_valid_credit: assert property (@(posedge pll_clk) disable iff (!arst_n)
		pkt_valid |-> in_flight < CREDIT_DEPTH)
	else begin
		err_count++;
		$error("pkt_valid high with no credit left");
	end

	a_credit_max: assert property (@(posedge pll_clk) disable iff (!arst_n)
		credit <= CREDIT_DEPTH && int'(credit) + in_flight == CREDIT_DEPTH)
	else begin
		err_count++;
		$error("credit count above CREDIT_DEPTH or out of step with the words sent");
	end

	a_last_valid: assert property (@(posedge pll_clk) disable iff (!arst_n)
		pkt_last |-> pkt_valid && word_pos == FRAME_WORDS - 1)
	else begin
		err_count++;
		$error("pkt_last high without pkt_valid or away from the final word");
	end

endmodule

bind frame_tx xcorr_properties #(
	.NUM_LINES    (NUM_LINES),
	.MAX_LAG      (MAX_LAG),
	.CREDIT_DEPTH (CREDIT_DEPTH)
) u_props (
	.pll_clk       (pll_clk),
	.arst_n        (arst_n),
	.pkt_valid     (pkt_valid),
	.pkt_last      (pkt_last),
	.credit_return (credit_return),
	.credit        (credit)
);

//--- verif/xcorr_tb.sv
`timescale 1ns/1ps

module xcorr_tb import xcorr_pkg::*; ();

	localparam int NUM_LINES    = 3;
	localparam int MAX_LAG      = 4;
	localparam int INTEG_CYCLES = 64;
	localparam int CREDIT_DEPTH = 4;
	localparam int RES_MAIN     = 16;
	localparam int RES_SAT      = 5;
	localparam int NUM_TESTS    = 4;
	localparam int FW           = frame_words(NUM_LINES, MAX_LAG);
	localparam int CYCLE_LIMIT  = NUM_TESTS * 40 * INTEG_CYCLES;
	localparam int PROMPT = 0, SLOW = 1, HOLD = 2; // Receiver credit modes

	logic pll_clk, arst_n, credit_return, credit_return_sat;
	logic [NUM_LINES-1:0] line_in, line_in_sat;
	word_t pkt_word, pkt_word_sat;
	word_kind_e pkt_kind, pkt_kind_sat;
	logic pkt_valid, pkt_last, pkt_valid_sat, pkt_last_sat;

	logic [NUM_LINES-1:0] samples[$]; // Main DUT samples by sample number
	int density[NUM_LINES];           // Pulse probability per line in percent
	int test_errs[NUM_TESTS] = '{default: 0};
	int test_checks[NUM_TESTS] = '{default: 0};
	string test_name[NUM_TESTS] = '{"auto_cross_counts", "credit_backpressure",
		"dropped_windows", "saturation"};
	int frames[2] = '{0, 0};    // Receiver 1 serves the saturation DUT
	int pos[2] = '{0, 0};
	int cur_win[2] = '{0, 0};
	int prev_win[2] = '{-1, -1};
	int held[2] = '{0, 0};      // Words held without a returned credit
	int wait_cnt[2] = '{0, 0};
	int cycle_cnt = 0;
	int cur_test, mode, drops_seen, total_errs, assert_errs, passed;

	xcorr_top #(.NUM_LINES(NUM_LINES), .MAX_LAG(MAX_LAG), .RESOLUTION(RES_MAIN),
		.INTEG_CYCLES(INTEG_CYCLES), .CREDIT_DEPTH(CREDIT_DEPTH)) u_dut (.pll_clk, .arst_n,
		.line_in, .credit_return, .pkt_word, .pkt_kind, .pkt_valid, .pkt_last);

	// All lines held high against a 5-bit counter
	xcorr_top #(.NUM_LINES(NUM_LINES), .MAX_LAG(MAX_LAG), .RESOLUTION(RES_SAT),
		.INTEG_CYCLES(INTEG_CYCLES), .CREDIT_DEPTH(CREDIT_DEPTH)) u_dut_sat (.pll_clk, .arst_n,
		.line_in(line_in_sat), .credit_return(credit_return_sat), .pkt_word(pkt_word_sat),
		.pkt_kind(pkt_kind_sat), .pkt_valid(pkt_valid_sat), .pkt_last(pkt_last_sat));

	function automatic bit sample_bit(int d, int line, int s);
		if (s < 0)
			return 1'b0; // Nothing before the first sample
		return (d == 1) ? 1'b1 : samples[s][line];
	endfunction

	// Auto terms first and then pairs (0,1) (0,2) ... (1,2) with lags ascending
	function automatic int expected_term(int d, int w, int t);
		int a, b, lag, p, cnt, cap;
		a = t / MAX_LAG;
		b = a;
		lag = t % MAX_LAG;
		if (t >= NUM_LINES * MAX_LAG) begin
			p = t / MAX_LAG - NUM_LINES;
			for (int i = 0; i < NUM_LINES; i++) begin
				for (int j = i + 1; j < NUM_LINES; j++) begin
					if (p == 0) begin
						a = i;
						b = j;
					end
					p--;
				end
			end
		end
		cnt = 0;
		for (int s = w * INTEG_CYCLES; s < (w + 1) * INTEG_CYCLES; s++) begin
			if (sample_bit(d, a, s) && sample_bit(d, b, s - lag))
				cnt++;
		end
		cap = (1 << ((d == 0) ? RES_MAIN : RES_SAT)) - 1;
		return (cnt > cap) ? cap : cnt;
	endfunction

	task automatic note_error(int tn, string msg);
		test_errs[tn]++;
		$display("error %s: %s", test_name[tn], msg);
	endtask

	task automatic check_word(int tn, string what, word_t exp, word_t act);
		test_checks[tn]++;
		if (act !== exp) begin
			test_errs[tn]++;
			$display("mismatch %s %s: expected %h actual %h", test_name[tn], what, exp, act);
		end
	endtask

	task automatic check_kind(int tn, string what, word_kind_e exp, word_kind_e act);
		test_checks[tn]++;
		if (act !== exp) begin
			test_errs[tn]++;
			$display("mismatch %s %s: expected %0d actual %0d", test_name[tn], what, exp, act);
		end
	endtask

	task automatic check_flag(int tn, string what, logic exp, logic act);
		test_checks[tn]++;
		if (act !== exp) begin
			test_errs[tn]++;
			$display("mismatch %s %s: expected %b actual %b", test_name[tn], what, exp, act);
		end
	endtask

	task automatic receive_word(int d, word_t word, word_kind_e kind, logic last);
		int tn, w, drop;
		tn = (d == 1) ? 3 : cur_test;
		held[d]++;
		if (held[d] > CREDIT_DEPTH)
			note_error(tn, "more words arrived than credits allow");
		if (pos[d] == 0) begin
			w = prev_win[d] + 1; // Full window number from the 8-bit sequence field
			while (w % 256 != word[7:0])
				w++;
			drop = (w - prev_win[d] - 1 > 15) ? 15 : w - prev_win[d] - 1;
			if ((w + 1) * INTEG_CYCLES > samples.size())
				note_error(tn, "header names a window that has not ended yet");
			if (d == 0 && cur_test == 2 && drop > 0)
				drops_seen++;
			check_kind(tn, "header kind", WK_HEADER, kind);
			check_word(tn, "header", {FRAME_TAG, 4'(drop), 8'(w)}, word);
			cur_win[d] = w;
			prev_win[d] = w;
		end else begin
			check_kind(tn, $sformatf("kind %0d", pos[d]),
				(pos[d] <= NUM_LINES * MAX_LAG) ? WK_AUTO : WK_CROSS, kind);
			check_word(tn, $sformatf("window %0d word %0d", cur_win[d], pos[d]),
				word_t'(expected_term(d, cur_win[d], pos[d] - 1)), word);
		end
		check_flag(tn, $sformatf("last %0d", pos[d]), pos[d] == FW - 1, last);
		if (pos[d] == FW - 1) begin
			pos[d] = 0;
			frames[d]++;
		end else begin
			pos[d]++;
		end
	endtask

	task automatic return_credit(int d, int m, output logic ret);
		ret = 1'b0;
		if (held[d] > 0 && m != HOLD) begin
			if (wait_cnt[d] > 0) begin
				wait_cnt[d]--;
			end else begin
				ret = 1'b1;
				held[d]--;
				wait_cnt[d] = (m == SLOW) ? $urandom_range(7, 0) : 0;
			end
		end
	endtask

	// Outputs are read mid-cycle before the next inputs go out
	task automatic drive_and_monitor();
		repeat (8) @(posedge pll_clk);
		forever begin
			@(negedge pll_clk);
			if (pkt_valid)
				receive_word(0, pkt_word, pkt_kind, pkt_last);
			if (pkt_valid_sat)
				receive_word(1, pkt_word_sat, pkt_kind_sat, pkt_last_sat);
			return_credit(0, mode, credit_return);
			return_credit(1, PROMPT, credit_return_sat);
			for (int i = 0; i < NUM_LINES; i++)
				line_in[i] = ($urandom_range(99, 0) < density[i]);
			samples.push_back(line_in); // Taken at the next rising edge
			arst_n = 1'b1;
		end
	endtask

	task automatic run_phase(int tn, int m, int n);
		int target;
		cur_test = tn;
		mode = m;
		for (int i = 0; i < NUM_LINES; i++)
			density[i] = $urandom_range(90, 10);
		target = frames[0] + n;
		while (frames[0] < target)
			@(posedge pll_clk);
	endtask

	task automatic report_test(int tn);
		$display("test %-20s checks %0d errors %0d %s", test_name[tn], test_checks[tn],
			test_errs[tn], (test_errs[tn] == 0) ? "ok" : "failed");
	endtask

	initial begin
		pll_clk = 1'b0;
		forever #2 pll_clk = ~pll_clk;
	end

	always @(posedge pll_clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h075e_f109));
		arst_n = 1'b0;
		line_in = '0;
		line_in_sat = '1;
		credit_return = 1'b0;
		credit_return_sat = 1'b0;
		drops_seen = 0;
		fork
			drive_and_monitor();
		join_none
		run_phase(0, PROMPT, 5);
		report_test(0);
		run_phase(1, SLOW, 4);
		report_test(1);
		run_phase(2, HOLD, 0);
		repeat (4 * INTEG_CYCLES) @(posedge pll_clk); // Frame stalls over several windows
		run_phase(2, PROMPT, 3);
		if (drops_seen == 0)
			note_error(2, "no window was dropped while credits were withheld");
		report_test(2);
		if (frames[1] == 0)
			note_error(3, "no frame came out of the saturation DUT");
		report_test(3);
		assert_errs = u_dut.u_tx.u_props.err_count + u_dut_sat.u_tx.u_props.err_count;
		total_errs = assert_errs;
		passed = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total_errs += test_errs[t];
			if (test_errs[t] == 0)
				passed++;
		end
		$display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
			NUM_TESTS, passed, NUM_TESTS - passed, total_errs, assert_errs);
		if (total_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- filelist.f
common/xcorr_pkg.sv
common/frame_buf_if.sv
correlator/tap_delay_line.sv
correlator/lag_counter_bank.sv
hdl/integration_ctrl.sv
hdl/frame_tx.sv
hdl/xcorr_top.sv
verif/xcorr_properties.sv
verif/xcorr_tb.sv
